/* source/oramPkg.sv */
package oramPkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int ByteWidth = 8; // One UART symbol
	localparam int OpWidth = 8;
	localparam int AddrWidth = 32;
	localparam int DataWidth = 32; // Store word and response
	localparam int CmdWidth = OpWidth + AddrWidth + DataWidth; // 72 bits, 9 bytes on the wire

	// Store geometry, addresses alias modulo depth
	localparam int StoreDepth = 256;
	localparam int StoreAddrWidth = $clog2(StoreDepth);

	// Opcodes
	localparam logic [OpWidth-1:0] OpUpdate = 8'd0;
	localparam logic [OpWidth-1:0] OpRead = 8'd2;

	// --------------------------------------------------
	// UART timing
	// --------------------------------------------------
	localparam int ClocksPerBit = 16;
	localparam int BitTimerWidth = $clog2(ClocksPerBit);
	localparam logic [BitTimerWidth-1:0] LastBitTick = BitTimerWidth'(ClocksPerBit - 1);
	localparam logic [BitTimerWidth-1:0] HalfBitTick = BitTimerWidth'(ClocksPerBit / 2 - 1);
	localparam int ByteCntWidth = $clog2(ByteWidth);
	localparam logic [ByteCntWidth-1:0] LastDataBit = ByteCntWidth'(ByteWidth - 1);
	localparam int FrameBits = ByteWidth + 2; // Start + data + stop
	localparam int FrameCntWidth = $clog2(FrameBits);
	localparam logic [FrameCntWidth-1:0] LastFrameBit = FrameCntWidth'(FrameBits - 1);

	// --------------------------------------------------
	// Command and response
	// --------------------------------------------------
	typedef struct packed {
		logic [OpWidth-1:0] op; // Top byte, sent first
		logic [AddrWidth-1:0] addr;
		logic [DataWidth-1:0] data; // Ignored for reads
	} cmdT;

	typedef struct packed {
		logic [DataWidth-1:0] data;
	} respT;

endpackage

/* source/uartRx.sv */
`timescale 1ns/1ps

module uartRx (
	input logic sys_clk_p,
	input logic rst,
	input logic rxd,
	output logic [oramPkg::ByteWidth-1:0] rxByte,
	output logic rxValid
);

	typedef enum logic [1:0] {
		RxIdle,
		RxStart,
		RxData,
		RxStop
	} rxStateT;

	rxStateT state;
	logic [1:0] rxdSync; // Two-flop synchronizer
	logic rxdPrev; // For edge detect
	logic [oramPkg::BitTimerWidth-1:0] clkCnt;
	logic [oramPkg::ByteCntWidth-1:0] bitCnt;
	logic [oramPkg::ByteWidth-1:0] shiftReg; // Payload, no reset
	logic rxBit;

	assign rxBit = rxdSync[1];
	assign rxByte = shiftReg;

	// --------------------------------------------------
	// Line synchronizer
	// --------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (rst) begin
			rxdSync <= 2'b11; // Line idles high
			rxdPrev <= 1'b1;
		end else begin
			rxdSync <= {rxdSync[0], rxd};
			rxdPrev <= rxBit;
		end
	end

	// --------------------------------------------------
	// Frame FSM
	// --------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (rst) begin
			state <= RxIdle;
			clkCnt <= '0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0; // Single-cycle pulse
			clkCnt <= clkCnt + 1'b1;
			case (state)
				RxIdle: begin
					clkCnt <= '0;
					if (rxdPrev && !rxBit) state <= RxStart; // Falling edge
				end
				RxStart: begin
					if (clkCnt == oramPkg::HalfBitTick) begin // Mid start bit
						clkCnt <= '0;
						bitCnt <= '0;
						state <= rxBit ? RxIdle : RxData; // Glitch, back to idle
					end
				end
				RxData: begin
					if (clkCnt == oramPkg::LastBitTick) begin
						clkCnt <= '0;
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == oramPkg::LastDataBit) state <= RxStop;
					end
				end
				RxStop: begin
					if (clkCnt == oramPkg::LastBitTick) begin
						state <= RxIdle;
						rxValid <= rxBit; // Bad stop bit drops the frame
					end
				end
				default: state <= RxIdle;
			endcase
		end
	end

	// Data bits arrive LSB first, shift in from the top
	always_ff @(posedge sys_clk_p) begin
		if (state == RxData && clkCnt == oramPkg::LastBitTick)
			shiftReg <= {rxBit, shiftReg[oramPkg::ByteWidth-1:1]};
	end

endmodule

/* source/uartTx.sv */
`timescale 1ns/1ps

module uartTx (
	input logic sys_clk_p,
	input logic rst,
	input logic [oramPkg::ByteWidth-1:0] txByte,
	input logic txValid,
	output logic txReady,
	output logic txd
);

	logic busy;
	logic [oramPkg::FrameBits-1:0] frame; // Bit 0 is on the line
	logic [oramPkg::BitTimerWidth-1:0] clkCnt;
	logic [oramPkg::FrameCntWidth-1:0] bitCnt;
	logic txFire;

	assign txReady = ~busy; // Only while idle
	assign txFire = txValid & txReady;
	assign txd = frame[0];

	// --------------------------------------------------
	// Frame shifter
	// --------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (rst) begin
			busy <= 1'b0;
			frame <= '1; // Line rests high
			clkCnt <= '0;
			bitCnt <= '0;
		end else if (txFire) begin
			busy <= 1'b1;
			frame <= {1'b1, txByte, 1'b0}; // Stop, data, start
			clkCnt <= '0;
			bitCnt <= '0;
		end else if (busy) begin
			clkCnt <= clkCnt + 1'b1;
			if (clkCnt == oramPkg::LastBitTick) begin // End of bit time
				clkCnt <= '0;
				frame <= {1'b1, frame[oramPkg::FrameBits-1:1]}; // Fill with idle level
				bitCnt <= bitCnt + 1'b1;
				if (bitCnt == oramPkg::LastFrameBit) begin
					busy <= 1'b0; // Stop bit done
					bitCnt <= '0;
				end
			end
		end
	end

endmodule

/* source/widthShifter.sv */
`timescale 1ns/1ps

module widthShifter #(
	parameter int InWidth = 8,
	parameter int OutWidth = 32
) (
	input logic sys_clk_p,
	input logic rst,
	input logic [InWidth-1:0] inData,
	input logic inValid,
	output logic inReady,
	output logic [OutWidth-1:0] outData,
	output logic outValid,
	input logic outReady
);

	localparam bit Collect = OutWidth > InWidth;
	localparam int WideWidth = Collect ? OutWidth : InWidth;
	localparam int NarrowWidth = Collect ? InWidth : OutWidth;
	localparam int Ratio = WideWidth / NarrowWidth; // Parts per word
	localparam int CntWidth = (Ratio > 1) ? $clog2(Ratio) : 1;
	localparam logic [CntWidth-1:0] LastPart = CntWidth'(Ratio - 1);

	logic [WideWidth-1:0] wideReg; // Payload, no reset
	logic [CntWidth-1:0] partCnt;
	logic busy; // Full word held (collect) or parts left (split)
	logic inFire, outFire;
	logic partFire, lastPart;
	logic fillDone, drainDone;

	assign inReady = ~busy;
	assign outValid = busy;
	assign inFire = inValid & inReady;
	assign outFire = outValid & outReady;
	assign lastPart = partFire && (partCnt == LastPart);

	// --------------------------------------------------
	// Data path per direction
	// --------------------------------------------------
	generate
		if (Collect) begin : gCollect
			assign partFire = inFire; // Count incoming parts
			assign fillDone = lastPart;
			assign drainDone = outFire;
			assign outData = wideReg;
			always_ff @(posedge sys_clk_p) begin
				if (inFire) wideReg <= {wideReg[WideWidth-NarrowWidth-1:0], inData}; // First in ends on top
			end
		end else begin : gSplit
			assign partFire = outFire; // Count outgoing parts
			assign fillDone = inFire;
			assign drainDone = lastPart;
			assign outData = wideReg[WideWidth-1 -: NarrowWidth]; // MS part first
			always_ff @(posedge sys_clk_p) begin
				if (inFire) wideReg <= inData;
				else if (outFire) wideReg <= wideReg << NarrowWidth;
			end
		end
	endgenerate

	// Shared control
	always_ff @(posedge sys_clk_p) begin
		if (rst) begin
			partCnt <= '0;
			busy <= 1'b0;
		end else begin
			if (partFire) partCnt <= lastPart ? '0 : partCnt + 1'b1;
			if (fillDone) busy <= 1'b1;
			else if (drainDone) busy <= 1'b0;
		end
	end

endmodule

/* source/blockStore.sv */
`timescale 1ns/1ps

module blockStore (
	input logic sys_clk_p,
	input logic rst,
	input oramPkg::cmdT cmd,
	input logic cmdValid,
	output logic cmdReady,
	output oramPkg::respT resp,
	output logic respValid,
	input logic respReady
);

	logic [oramPkg::DataWidth-1:0] mem [oramPkg::StoreDepth]; // No reset
	logic [oramPkg::StoreAddrWidth-1:0] wordAddr;
	oramPkg::respT respReg;
	logic respFull;
	logic cmdFire;
	logic isUpdate, isRead;

	// Low address bits pick the word
	assign wordAddr = cmd.addr[oramPkg::StoreAddrWidth-1:0];
	assign cmdReady = ~respFull; // Stall while a response waits
	assign cmdFire = cmdValid & cmdReady;
	assign isUpdate = cmd.op == oramPkg::OpUpdate;
	assign isRead = cmd.op == oramPkg::OpRead;
	assign resp = respReg;
	assign respValid = respFull;

	// --------------------------------------------------
	// Memory
	// --------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (cmdFire && isUpdate) mem[wordAddr] <= cmd.data; // No response
	end

	always_ff @(posedge sys_clk_p) begin
		if (cmdFire && isRead) respReg.data <= mem[wordAddr];
	end

	// One-entry response register
	always_ff @(posedge sys_clk_p) begin
		if (rst) begin
			respFull <= 1'b0;
		end else if (cmdFire && isRead) begin
			respFull <= 1'b1;
		end else if (respFull && respReady) begin
			respFull <= 1'b0; // Taken by output shifter
		end
		// Other opcodes just consumed
	end

endmodule

/* source/blockStoreTop.sv */
`timescale 1ns/1ps

module blockStoreTop (
	input logic sys_clk_p,
	input logic rst,
	input logic rxd,
	output logic txd
);

	logic [oramPkg::ByteWidth-1:0] rxByte, txByte;
	logic rxValid, txValid, txReady;
	logic [oramPkg::CmdWidth-1:0] cmdVec;
	logic [oramPkg::DataWidth-1:0] respVec;
	logic cmdValid, cmdReady, respValid, respReady;
	oramPkg::cmdT cmd;
	oramPkg::respT resp;

	assign cmd = oramPkg::cmdT'(cmdVec);
	assign respVec = resp;

	// --------------------------------------------------
	// Host to store
	// --------------------------------------------------
	uartRx uartRxInst (
		.sys_clk_p(sys_clk_p),
		.rst(rst),
		.rxd(rxd),
		.rxByte(rxByte),
		.rxValid(rxValid)
	);

	// Receiver has no back-pressure, bytes past a stalled command are lost
	widthShifter #(.InWidth(oramPkg::ByteWidth), .OutWidth(oramPkg::CmdWidth)) cmdShifter (
		.sys_clk_p(sys_clk_p),
		.rst(rst),
		.inData(rxByte),
		.inValid(rxValid),
		.inReady(),
		.outData(cmdVec),
		.outValid(cmdValid),
		.outReady(cmdReady)
	);

	blockStore store (
		.sys_clk_p(sys_clk_p),
		.rst(rst),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.resp(resp),
		.respValid(respValid),
		.respReady(respReady)
	);

	// --------------------------------------------------
	// Store to host
	// --------------------------------------------------
	widthShifter #(.InWidth(oramPkg::DataWidth), .OutWidth(oramPkg::ByteWidth)) respShifter (
		.sys_clk_p(sys_clk_p),
		.rst(rst),
		.inData(respVec),
		.inValid(respValid),
		.inReady(respReady),
		.outData(txByte),
		.outValid(txValid),
		.outReady(txReady) // Busy UART stalls the chain
	);

	uartTx uartTxInst (
		.sys_clk_p(sys_clk_p),
		.rst(rst),
		.txByte(txByte),
		.txValid(txValid),
		.txReady(txReady),
		.txd(txd)
	);

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
	output logic sys_clk_p,
	output logic rst
);

	// 100 ns period
	initial begin
		sys_clk_p = 1'b0;
		forever #50 sys_clk_p = ~sys_clk_p;
	end

	// Reset for the first 16 rising edges
	initial begin
		rst <= 1'b1;
		repeat (16) @(posedge sys_clk_p);
		rst <= 1'b0; // Released on an edge
	end

endmodule

/* tests/blockStoreTb.sv */
`timescale 1ns/1ps

module blockStoreTb;

	logic sys_clk_p, rst;
	logic rxd, txd;
	logic [31:0] lfsrState;
	logic [31:0] modelMem [oramPkg::StoreDepth]; // Expected store contents
	int errors, checks;

	clockGen clockGenInst (
		.sys_clk_p(sys_clk_p),
		.rst(rst)
	);

	blockStoreTop blockStoreTop_inst (
		.sys_clk_p(sys_clk_p),
		.rst(rst),
		.rxd(rxd),
		.txd(txd)
	);

	// --------------------------------------------------
	// Random data and bookkeeping
	// --------------------------------------------------
	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) next = next ^ 32'h8020_0003;
		return next;
	endfunction

	task automatic randomWord(output logic [31:0] value);
		value = '0;
		for (int i = 0; i < 32; i++) begin
			lfsrState = lfsrNext(lfsrState); // One step per bit
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic finishRun();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) $display("Everything OK");
		else $display("Something failed");
		$finish;
	endtask

	task automatic timedOut(input string what);
		errors++;
		$display("Timed out waiting for %s", what);
	endtask

	task automatic compareWord(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// --------------------------------------------------
	// UART host model
	// --------------------------------------------------
	task automatic sendByte(input logic [oramPkg::ByteWidth-1:0] value);
		logic [oramPkg::FrameBits-1:0] frame;
		frame = {1'b1, value, 1'b0}; // Stop, data, start
		for (int i = 0; i < oramPkg::FrameBits; i++) begin
			@(posedge sys_clk_p);
			rxd <= frame[i];
			repeat (oramPkg::ClocksPerBit - 1) @(posedge sys_clk_p); // Hold one bit time
		end
	endtask

	task automatic sendCmd(input logic [7:0] op, input logic [31:0] addr,
			input logic [31:0] data);
		logic [71:0] cmd;
		cmd = {op, addr, data};
		for (int i = 8; i >= 0; i--) sendByte(cmd[i*8 +: 8]); // MS byte first
	endtask

	task automatic recvByte(output logic [7:0] value);
		int waited;
		waited = 0;
		value = '0;
		@(negedge sys_clk_p);
		while (txd && waited < 200 * oramPkg::ClocksPerBit) begin
			@(negedge sys_clk_p);
			waited++;
		end
		if (txd) begin
			timedOut("a start bit on txd");
		end else begin
			repeat (oramPkg::ClocksPerBit / 2) @(negedge sys_clk_p); // Near middle of start bit
			for (int i = 0; i < 8; i++) begin
				repeat (oramPkg::ClocksPerBit) @(negedge sys_clk_p);
				value[i] = txd; // LSB first
			end
			repeat (oramPkg::ClocksPerBit) @(negedge sys_clk_p);
			checks++;
			if (txd !== 1'b1) begin
				errors++;
				$display("Fail at %0d ns: txd stop bit expected 1, got %b", $time, txd);
			end
		end
	endtask

	task automatic recvWord(output logic [31:0] word);
		logic [7:0] part;
		word = '0;
		for (int i = 0; i < 4; i++) begin
			recvByte(part);
			word = {word[23:0], part}; // MS byte arrives first
		end
	endtask

	task automatic updateWord(input logic [31:0] addr, input logic [31:0] data);
		sendCmd(oramPkg::OpUpdate, addr, data);
		modelMem[addr[7:0]] = data; // Aliases modulo 256
	endtask

	// Receiver runs alongside since the response can start before the last stop bit ends
	task automatic readCheck(input logic [31:0] addr);
		logic [31:0] word;
		fork
			sendCmd(oramPkg::OpRead, addr, 32'h0);
			recvWord(word);
		join
		compareWord("resp.data", modelMem[addr[7:0]], word);
	endtask

	task automatic quietLine(input int cycles);
		logic seenLow;
		seenLow = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge sys_clk_p);
			if (txd !== 1'b1 && !seenLow) begin
				seenLow = 1'b1; // Report once
				errors++;
				$display("Fail at %0d ns: txd expected 1, got %b", $time, txd);
			end
		end
		checks++;
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic writeThenRead();
		logic [31:0] addrs [3];
		logic [31:0] value;
		addrs = '{32'h10, 32'h2a5, 32'hff};
		foreach (addrs[i]) begin
			randomWord(value);
			updateWord(addrs[i], value);
		end
		foreach (addrs[i]) readCheck(addrs[i]);
	endtask

	task automatic overwriteAlias();
		logic [31:0] first, second;
		randomWord(first);
		updateWord(32'h38c, first);
		randomWord(second);
		updateWord(32'h08c, second); // Same low byte
		readCheck(32'h38c);
	endtask

	task automatic unknownOpcode();
		logic [31:0] value;
		randomWord(value);
		sendCmd(8'hff, 32'h10, value);
		quietLine(30 * oramPkg::ClocksPerBit); // No response expected
		readCheck(32'h10);
	endtask

	task automatic backToBackReads();
		logic [31:0] addrs [4];
		logic [31:0] expected [$];
		logic [31:0] word;
		addrs = '{32'h2a5, 32'h10, 32'h38c, 32'hff};
		foreach (addrs[i]) expected.push_back(modelMem[addrs[i][7:0]]);
		fork
			begin
				foreach (addrs[i]) sendCmd(oramPkg::OpRead, addrs[i], 32'h0);
			end
			begin
				for (int i = 0; i < 4; i++) begin
					recvWord(word);
					compareWord("resp.data", expected.pop_front(), word); // In order
				end
			end
		join
	endtask

	initial begin
		int waited;
		errors = 0;
		checks = 0;
		waited = 0;
		lfsrState = 32'hf0c3;
		rxd <= 1'b1; // Line idles high
		while (rst !== 1'b0 && waited < 100) begin
			@(posedge sys_clk_p);
			waited++;
		end
		if (rst !== 1'b0) begin
			timedOut("reset to be released");
		end else begin
			quietLine(100); // Idle line after reset
			writeThenRead();
			overwriteAlias();
			unknownOpcode();
			backToBackReads();
		end
		finishRun();
	end

endmodule

/* filelist.f */
source/oramPkg.sv
source/uartRx.sv
source/uartTx.sv
source/widthShifter.sv
source/blockStore.sv
source/blockStoreTop.sv
tests/clockGen.sv
tests/blockStoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module blockStoreTb \
	-f filelist.f \
	-o blockStoreSim

./obj_dir/blockStoreSim | tee sim.log

if grep -q "Everything OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
